// File: run_sim.sh
#!/usr/bin/env bash
# Build the data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module dcache_tb \
	-Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

// File: source/bus_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_beat_counter import l1d_pkg::*;
	(input wire clk,
	input wire reset,
	input wire start,
	input wire [2:0] len,
	input wire ack,
	output l1d_word_idx_t word,
	output logic last);

	l1d_word_idx_t last_idx;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			word <= '0;
			last_idx <= '0;
		end
		else if (start)
		begin
			word <= '0;
			// Length of 1 or 4 beats kept as the final index
			last_idx <= l1d_word_idx_t'(len - 3'd1);
		end
		else if (ack)
			word <= word + 1'b1;
	end

	assign last = word == last_idx;
endmodule

`default_nettype wire

// File: source/cache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lru import l1d_pkg::*;
	(input wire clk,
	input wire reset,
	input wire access_en,
	input wire l1d_set_idx_t access_set,
	input wire update_en,
	input wire l1d_way_idx_t update_way,
	input wire fill_en,
	input wire l1d_set_idx_t fill_set,
	input wire l1d_way_idx_t fill_way,
	output l1d_way_idx_t victim_way);

	// Bit 0 is the root, bit 1 picks in pair 0, bit 2 picks in pair 1
	// A bit value points at the side to evict next
	logic [2:0] tree[L1D_SETS];
	logic [2:0] bits_q;
	logic [2:0] read_bits;
	l1d_set_idx_t access_set_q;

	// Point every bit on the way's path away from it
	function automatic logic [2:0] touch(input logic [2:0] bits, input l1d_way_idx_t way);
		logic [2:0] result;
		result = bits;
		result[0] = !way[1];
		if (way[1])
			result[2] = !way[0];
		else
			result[1] = !way[0];
		return result;
	endfunction

	// Forward updates landing on the set being read this cycle
	always_comb
	begin
		read_bits = tree[access_set];
		if (update_en && access_set_q == access_set)
			read_bits = touch(read_bits, update_way);
		if (fill_en && fill_set == access_set)
			read_bits = touch(read_bits, fill_way);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < L1D_SETS; i++)
				tree[i] <= '0;
			bits_q <= '0;
			access_set_q <= '0;
		end
		else
		begin
			// Hits always refer to the set registered with the data stage
			if (update_en)
				tree[access_set_q] <= touch(tree[access_set_q], update_way);
			if (fill_en)
				tree[fill_set] <= touch(tree[fill_set], fill_way);
			if (access_en)
			begin
				access_set_q <= access_set;
				bits_q <= read_bits;
			end
		end
	end

	assign victim_way = bits_q[0] ? {1'b1, bits_q[2]} : {1'b0, bits_q[1]};
endmodule

`default_nettype wire

// File: source/dcache_data_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_stage import l1d_pkg::*;
	(input wire clk,
	input wire reset,

	// From tag stage
	input wire dt_valid,
	input wire dt_store,
	input wire l1d_addr_t dt_addr,
	input wire [31:0] dt_store_value,
	input wire [L1D_WAYS - 1:0] dt_way_valid,
	input wire l1d_tag_t dt_way_tag[L1D_WAYS],
	input wire [31:0] dt_way_data[L1D_WAYS],

	// LRU
	input wire l1d_way_idx_t victim_way,
	output logic lru_update_en,
	output l1d_way_idx_t lru_update_way,

	// Store hit write into the data RAM
	line_write_if.source line_write,

	// Bus FSM
	input wire busy,
	output logic bus_req,
	output bus_op_t bus_op,
	output l1d_addr_t bus_addr,
	output logic [31:0] bus_store_value,
	output l1d_way_idx_t bus_victim,
	input wire bus_resp,
	input wire [31:0] bus_resp_data,

	// CPU response
	output logic resp_valid,
	output logic [31:0] resp_data);

	logic [L1D_WAYS - 1:0] hit_oh;
	l1d_way_idx_t hit_way;
	logic is_io;
	logic is_hit;
	logic active;
	logic hit_resp;
	logic [31:0] hit_data;

	// Held requests wait until the bus FSM is done
	assign active = dt_valid && !busy;
	assign is_io = dt_addr.raw[31:16] == IO_PAGE;

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < L1D_WAYS; w++)
		begin
			hit_oh[w] = dt_way_valid[w] && dt_way_tag[w] == dt_addr.f.tag;
			if (hit_oh[w])
				hit_way = l1d_way_idx_t'(w);
		end
	end

	// I/O space never hits, even on a stray tag match
	assign is_hit = |hit_oh && !is_io;

	// Loads that hit touch the LRU
	assign lru_update_en = active && is_hit && !dt_store;
	assign lru_update_way = hit_way;

	// Write-through store that hits also patches the cached copy
	assign line_write.en = active && is_hit && dt_store;
	assign line_write.set_idx = dt_addr.f.set_idx;
	assign line_write.way = hit_way;
	assign line_write.word_idx = dt_addr.f.word_idx;
	assign line_write.data = dt_store_value;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			hit_resp <= 1'b0;
			bus_req <= 1'b0;
		end
		else
		begin
			hit_resp <= lru_update_en;
			// Everything except a load hit goes out on the bus
			bus_req <= active && (dt_store || !is_hit);
		end
	end

	always_ff @(posedge clk)
	begin
		hit_data <= dt_way_data[hit_way];
		if (dt_store)
			bus_op <= BUS_WRITE;
		else if (is_io)
			bus_op <= BUS_UNCACHED_READ;
		else
			bus_op <= BUS_FILL;
		bus_addr <= dt_addr;
		bus_store_value <= dt_store_value;
		bus_victim <= victim_way;
	end

	// Hits and bus responses never coincide, busy blocks hits
	assign resp_valid = hit_resp || bus_resp;
	assign resp_data = bus_resp ? bus_resp_data : hit_data;
endmodule

`default_nettype wire

// File: source/dcache_if.sv
`timescale 1ns/1ps
`default_nettype none

// Tag RAM and valid bit update, one-hot way select
interface tag_update_if import l1d_pkg::*; ();
	logic [L1D_WAYS - 1:0] en_oh;
	l1d_set_idx_t set_idx;
	l1d_tag_t tag;
	logic valid;

	modport source(output en_oh, set_idx, tag, valid);
	modport target(input en_oh, set_idx, tag, valid);
endinterface

// Single word write into one way's data RAM
interface line_write_if import l1d_pkg::*; ();
	logic en;
	l1d_set_idx_t set_idx;
	l1d_way_idx_t way;
	l1d_word_idx_t word_idx;
	logic [31:0] data;

	modport source(output en, set_idx, way, word_idx, data);
	modport target(input en, set_idx, way, word_idx, data);
endinterface

`default_nettype wire

// File: source/dcache_tag_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_stage import l1d_pkg::*;
	(input wire clk,
	input wire reset,

	// CPU request
	input wire req_valid,
	output logic req_ready,
	input wire req_store,
	input wire l1d_addr_t req_addr,
	input wire [31:0] req_store_value,

	// Bus FSM
	input wire busy,
	tag_update_if.target tag_update,
	line_write_if.target line_write,

	// To data stage
	output logic dt_valid,
	output logic dt_store,
	output l1d_addr_t dt_addr,
	output logic [31:0] dt_store_value,
	output logic [L1D_WAYS - 1:0] dt_way_valid,
	output l1d_tag_t dt_way_tag[L1D_WAYS],
	output logic [31:0] dt_way_data[L1D_WAYS]);

	logic accept;
	logic read_en;
	l1d_set_idx_t read_set;
	l1d_word_idx_t read_word;
	logic [L1D_SETS - 1:0] line_valid[L1D_WAYS];

	assign req_ready = !busy;
	assign accept = req_valid && req_ready;

	// While stalled, keep re-reading the held address so fills become visible
	assign read_en = accept || busy;
	assign read_set = busy ? dt_addr.f.set_idx : req_addr.f.set_idx;
	assign read_word = busy ? dt_addr.f.word_idx : req_addr.f.word_idx;

	genvar way_idx;
	generate
		for (way_idx = 0; way_idx < L1D_WAYS; way_idx++)
		begin : way_gen
			sram_1r1w #(.DATA_WIDTH(L1D_TAG_WIDTH), .SIZE(L1D_SETS)) tag_ram(
				.clk(clk),
				.read_en(read_en),
				.read_addr(read_set),
				.read_data(dt_way_tag[way_idx]),
				.write_en(tag_update.en_oh[way_idx]),
				.write_addr(tag_update.set_idx),
				.write_data(tag_update.tag));

			// Data RAM is indexed by set and word within the line
			sram_1r1w #(.DATA_WIDTH(32), .SIZE(L1D_SETS * L1D_WORDS_PER_LINE)) data_ram(
				.clk(clk),
				.read_en(read_en),
				.read_addr({read_set, read_word}),
				.read_data(dt_way_data[way_idx]),
				.write_en(line_write.en && line_write.way == l1d_way_idx_t'(way_idx)),
				.write_addr({line_write.set_idx, line_write.word_idx}),
				.write_data(line_write.data));

			always_ff @(posedge clk, posedge reset)
			begin
				if (reset)
				begin
					line_valid[way_idx] <= '0;
					dt_way_valid[way_idx] <= 1'b0;
				end
				else
				begin
					if (tag_update.en_oh[way_idx])
						line_valid[way_idx][tag_update.set_idx] <= tag_update.valid;
					if (read_en)
						dt_way_valid[way_idx] <= line_valid[way_idx][read_set];
				end
			end
		end
	endgenerate

	// Pipeline register, held while the bus FSM is working
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dt_valid <= 1'b0;
		else if (!busy)
			dt_valid <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			dt_store <= req_store;
			dt_addr <= req_addr;
			dt_store_value <= req_store_value;
		end
	end
endmodule

`default_nettype wire

// File: source/l1d_bus_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_bus_fsm import l1d_pkg::*;
	(input wire clk,
	input wire reset,

	// From data stage
	input wire bus_req,
	input wire bus_op_t bus_op,
	input wire l1d_addr_t bus_addr,
	input wire [31:0] bus_store_value,
	input wire l1d_way_idx_t bus_victim,
	output logic busy,
	output logic bus_resp,
	output logic [31:0] bus_resp_data,

	// Cache updates
	tag_update_if.source tag_update,
	line_write_if.source line_write,
	output logic lru_fill_en,
	output l1d_set_idx_t lru_fill_set,
	output l1d_way_idx_t lru_fill_way,

	// Beat counter
	output logic beat_start,
	output logic [2:0] beat_len,
	input wire l1d_word_idx_t beat_word,
	input wire beat_last,

	// Wishbone master
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [31:0] wb_adr,
	output logic [31:0] wb_dat_w,
	input wire [31:0] wb_dat_r,
	input wire wb_ack);

	typedef enum logic [1:0] {
		IDLE,
		BEAT,
		GAP,
		FINISH
	} state_t;

	state_t state;
	bus_op_t op;
	l1d_addr_t addr;
	logic [31:0] store_value;
	l1d_way_idx_t victim;
	logic settle;
	logic beat_ack;
	logic is_fill;

	assign is_fill = op == BUS_FILL;
	assign beat_ack = state == BEAT && wb_ack;

	// Extra settle cycle lets the stalled tag stage re-read the updated tags
	assign busy = state != IDLE || bus_req || settle;

	assign beat_start = state == IDLE && bus_req;
	assign beat_len = bus_op == BUS_FILL ? 3'd4 : 3'd1;

	// Wishbone signals follow the state and stay stable for the whole beat
	assign wb_cyc = state == BEAT;
	assign wb_stb = state == BEAT;
	assign wb_we = wb_cyc && op == BUS_WRITE;
	assign wb_dat_w = store_value;
	assign wb_adr = is_fill ? {addr.f.tag, addr.f.set_idx, beat_word} : addr.raw;

	// Fill beats land in the victim way as they arrive
	assign line_write.en = beat_ack && is_fill;
	assign line_write.set_idx = addr.f.set_idx;
	assign line_write.way = victim;
	assign line_write.word_idx = beat_word;
	assign line_write.data = wb_dat_r;

	// New line becomes valid only once all its words are written
	assign tag_update.en_oh = state == FINISH ? L1D_WAYS'(1) << victim : '0;
	assign tag_update.set_idx = addr.f.set_idx;
	assign tag_update.tag = addr.f.tag;
	assign tag_update.valid = 1'b1;

	assign lru_fill_en = state == FINISH;
	assign lru_fill_set = addr.f.set_idx;
	assign lru_fill_way = victim;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			settle <= 1'b0;
			bus_resp <= 1'b0;
		end
		else
		begin
			settle <= state == FINISH;
			// Answer on the requested word of a fill or on any single beat
			bus_resp <= beat_ack && (!is_fill || beat_word == addr.f.word_idx);
			case (state)
				IDLE:
					if (bus_req)
						state <= BEAT;
				BEAT:
					if (wb_ack)
					begin
						if (!beat_last)
							state <= GAP;
						else if (is_fill)
							state <= FINISH;
						else
							state <= IDLE;
					end
				GAP:
					state <= BEAT;
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (beat_start)
		begin
			op <= bus_op;
			addr <= bus_addr;
			store_value <= bus_store_value;
			victim <= bus_victim;
		end
		// Store acks return the written value
		if (beat_ack)
			bus_resp_data <= wb_we ? store_value : wb_dat_r;
	end
endmodule

`default_nettype wire

// File: source/l1d_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_cache_top import l1d_pkg::*;
	(input wire clk,
	input wire reset,

	// CPU side
	input wire req_valid,
	output logic req_ready,
	input wire req_store,
	input wire [31:0] req_addr,
	input wire [31:0] req_store_value,
	output logic resp_valid,
	output logic [31:0] resp_data,

	// Wishbone side
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [31:0] wb_adr,
	output logic [31:0] wb_dat_w,
	input wire [31:0] wb_dat_r,
	input wire wb_ack);

	l1d_addr_t request_addr;
	logic busy;
	logic dt_valid;
	logic dt_store;
	l1d_addr_t dt_addr;
	logic [31:0] dt_store_value;
	logic [L1D_WAYS - 1:0] dt_way_valid;
	l1d_tag_t dt_way_tag[L1D_WAYS];
	logic [31:0] dt_way_data[L1D_WAYS];
	l1d_way_idx_t victim_way;
	logic lru_update_en;
	l1d_way_idx_t lru_update_way;
	logic lru_fill_en;
	l1d_set_idx_t lru_fill_set;
	l1d_way_idx_t lru_fill_way;
	logic bus_req;
	bus_op_t bus_op;
	l1d_addr_t bus_addr;
	logic [31:0] bus_store_value;
	l1d_way_idx_t bus_victim;
	logic bus_resp;
	logic [31:0] bus_resp_data;
	logic beat_start;
	logic [2:0] beat_len;
	l1d_word_idx_t beat_word;
	logic beat_last;

	tag_update_if tag_update();
	line_write_if store_write();
	line_write_if fill_write();
	line_write_if ram_write();

	assign request_addr = req_addr;

	// Bus FSM owns the data RAM write port while busy
	assign ram_write.en = busy ? fill_write.en : store_write.en;
	assign ram_write.set_idx = busy ? fill_write.set_idx : store_write.set_idx;
	assign ram_write.way = busy ? fill_write.way : store_write.way;
	assign ram_write.word_idx = busy ? fill_write.word_idx : store_write.word_idx;
	assign ram_write.data = busy ? fill_write.data : store_write.data;

	dcache_tag_stage tag_stage(
		.req_addr(request_addr),
		.tag_update(tag_update.target),
		.line_write(ram_write.target),
		.*);

	dcache_data_stage data_stage(
		.line_write(store_write.source),
		.*);

	// LRU reads follow the new or held address of the tag stage
	cache_lru lru(
		.access_en((req_valid && req_ready) || busy),
		.access_set(busy ? dt_addr.f.set_idx : request_addr.f.set_idx),
		.update_en(lru_update_en),
		.update_way(lru_update_way),
		.fill_en(lru_fill_en),
		.fill_set(lru_fill_set),
		.fill_way(lru_fill_way),
		.*);

	l1d_bus_fsm bus_fsm(
		.tag_update(tag_update.source),
		.line_write(fill_write.source),
		.*);

	bus_beat_counter beat_counter(
		.start(beat_start),
		.len(beat_len),
		.ack(wb_cyc && wb_ack),
		.word(beat_word),
		.last(beat_last),
		.*);
endmodule

`default_nettype wire

// File: source/l1d_pkg.sv
`default_nettype none

package l1d_pkg;
	// Cache geometry
	localparam int L1D_WAYS = 4;
	localparam int L1D_SETS = 16;
	localparam int L1D_WORDS_PER_LINE = 4;
	localparam int L1D_TAG_WIDTH = 26;

	// Upper address half that selects uncached I/O space
	localparam logic [15:0] IO_PAGE = 16'hffff;

	typedef logic [$clog2(L1D_WAYS) - 1:0] l1d_way_idx_t;
	typedef logic [$clog2(L1D_SETS) - 1:0] l1d_set_idx_t;
	typedef logic [$clog2(L1D_WORDS_PER_LINE) - 1:0] l1d_word_idx_t;
	typedef logic [L1D_TAG_WIDTH - 1:0] l1d_tag_t;

	// Address fields, tag in the top bits, word offset at the bottom
	typedef struct packed {
		l1d_tag_t tag;
		l1d_set_idx_t set_idx;
		l1d_word_idx_t word_idx;
	} l1d_addr_fields_t;

	// Same 32 bits seen either as a raw word or split into fields
	typedef union packed {
		logic [31:0] raw;
		l1d_addr_fields_t f;
	} l1d_addr_t;

	// Work handed from the data stage to the bus FSM
	typedef enum logic [1:0] {
		BUS_FILL,
		BUS_UNCACHED_READ,
		BUS_WRITE
	} bus_op_t;
endpackage

`default_nettype wire

// File: source/sram_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w
	#(parameter int DATA_WIDTH = 32,
	parameter int SIZE = 64)
	(input wire clk,
	input wire read_en,
	input wire [$clog2(SIZE) - 1:0] read_addr,
	output logic [DATA_WIDTH - 1:0] read_data,
	input wire write_en,
	input wire [$clog2(SIZE) - 1:0] write_addr,
	input wire [DATA_WIDTH - 1:0] write_data);

	logic [DATA_WIDTH - 1:0] mem[SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;

		// Read during write to the same entry returns the old contents
		if (read_en)
			read_data <= mem[read_addr];
	end
endmodule

`default_nettype wire

// File: test/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import l1d_pkg::*; ();
	localparam int RESET_CYCLES = 16;
	localparam int OPERATION_COUNT = 30;
	// Slowest operation is a fill with three wait states on every beat plus pipeline and settle
	localparam int OPERATION_MAX_CYCLES = 40;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + OPERATION_COUNT * OPERATION_MAX_CYCLES);
	localparam int KIND_HIT = 0;
	localparam int KIND_FILL = 1;
	localparam int KIND_IO = 2;
	localparam int KIND_WRITE = 3;

	typedef struct packed {
		logic we;
		logic [31:0] adr;
		logic [31:0] dat;
	} beat_t;

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	logic req_ready;
	logic req_store;
	logic [31:0] req_addr;
	logic [31:0] req_store_value;
	logic resp_valid;
	logic [31:0] resp_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	int cycle = 0;
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	logic [31:0] lfsr_state = 32'hdefc;

	// Observed bus beats and responses
	beat_t beat_q[$];
	logic [31:0] resp_data_q[$];
	int resp_cycle_q[$];

	// Reference model in word addresses
	logic [31:0] shadow_mem[logic [31:0]];
	l1d_tag_t model_tag[L1D_SETS][L1D_WAYS];
	logic model_valid[L1D_SETS][L1D_WAYS];
	logic model_root[L1D_SETS];
	logic model_pair[L1D_SETS][2];

	l1d_cache_top DUT(.*);

	wb_memory_model #(.SEED(32'hdefc)) memory(.*);

	always #20 clk = !clk;

	// Run limit is twice the slowest length of all tests
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped after %0d cycles, a request or response never completed", cycle);
			$display("Regression failed");
			$finish;
		end
	end

	// Outputs move on rising edges and are sampled on falling ones
	always @(negedge clk)
	begin
		if (!reset && resp_valid)
		begin
			resp_data_q.push_back(resp_data);
			resp_cycle_q.push_back(cycle);
		end
		if (!reset && wb_cyc && wb_stb && wb_ack)
			beat_q.push_back({wb_we, wb_adr, wb_dat_w});
		// Strobe follows cyc on every classic Wishbone beat
		if (!reset && wb_stb !== wb_cyc)
			flag_mismatch("wb_stb", 32'(wb_cyc), 32'(wb_stb));
	end

	function automatic logic [31:0] lfsr_advance(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One LFSR step per bit
	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_advance(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	function automatic logic [31:0] initial_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
	endfunction

	function automatic logic [31:0] memory_word(input logic [31:0] addr);
		if (shadow_mem.exists(addr))
			return shadow_mem[addr];
		return initial_word(addr);
	endfunction

	task automatic flag_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %s: expected %h, got %h", name, expected, actual);
		error_count++;
	endtask

	task automatic flag_problem(input string text);
		$display("%s", text);
		error_count++;
	endtask

	// Root bit picks the pair to evict and the pair bit the way inside it
	task automatic model_touch(input int set_idx, input int way);
		model_root[set_idx] = way < 2;
		model_pair[set_idx][way / 2] = way % 2 == 0;
	endtask

	task automatic predict_load(input logic [31:0] addr, output int kind);
		int set_idx;
		int way;
		logic hit;
		set_idx = int'(addr[5:2]);
		hit = 1'b0;
		way = 0;
		if (addr[31:16] == IO_PAGE)
			kind = KIND_IO;
		else
		begin
			for (int w = 0; w < L1D_WAYS; w++)
			begin
				if (model_valid[set_idx][w] && model_tag[set_idx][w] == addr[31:6])
				begin
					hit = 1'b1;
					way = w;
				end
			end
			if (hit)
				kind = KIND_HIT;
			else
			begin
				kind = KIND_FILL;
				way = model_root[set_idx] ? 2 + int'(model_pair[set_idx][1])
					: int'(model_pair[set_idx][0]);
				model_tag[set_idx][way] = addr[31:6];
				model_valid[set_idx][way] = 1'b1;
			end
			model_touch(set_idx, way);
		end
	endtask

	// Leaves req_valid high for the caller to release or reuse
	task automatic drive_request(input logic store, input logic [31:0] addr,
		input logic [31:0] value, output int accept_cycle);
		req_valid = 1'b1;
		req_store = store;
		req_addr = addr;
		req_store_value = value;
		while (!req_ready)
			@(negedge clk);
		accept_cycle = cycle;
		@(negedge clk);
	endtask

	task automatic release_request();
		req_valid = 1'b0;
		req_store = 1'b0;
	endtask

	task automatic wait_response(output logic [31:0] data, output int at_cycle);
		while (resp_data_q.size() == 0)
			@(negedge clk);
		data = resp_data_q.pop_front();
		at_cycle = resp_cycle_q.pop_front();
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic check_beats(input int kind, input logic [31:0] addr, input logic [31:0] value);
		int expected_count;
		beat_t beat;
		logic [31:0] expected_adr;
		expected_count = kind == KIND_HIT ? 0 : (kind == KIND_FILL ? 4 : 1);
		if (beat_q.size() != expected_count)
		begin
			flag_mismatch("Wishbone beat count", 32'(expected_count), 32'(beat_q.size()));
			beat_q.delete();
			return;
		end
		for (int i = 0; i < expected_count; i++)
		begin
			beat = beat_q[i];
			// Fill walks its line in ascending word order
			expected_adr = kind == KIND_FILL ? {addr[31:2], 2'(i)} : addr;
			if (beat.adr !== expected_adr)
				flag_mismatch("wb_adr", expected_adr, beat.adr);
			if (beat.we !== (kind == KIND_WRITE))
				flag_mismatch("wb_we", 32'(kind == KIND_WRITE), 32'(beat.we));
			if (kind == KIND_WRITE && beat.dat !== value)
				flag_mismatch("wb_dat_w", value, beat.dat);
		end
		beat_q.delete();
	endtask

	task automatic check_quiet();
		if (resp_data_q.size() != 0)
			flag_problem("Response arrived with no request waiting for it");
		resp_data_q.delete();
		resp_cycle_q.delete();
	endtask

	task automatic check_load(input logic [31:0] addr);
		int kind;
		int accept_cycle;
		int resp_cycle;
		logic [31:0] data;
		predict_load(addr, kind);
		drive_request(1'b0, addr, 32'h0, accept_cycle);
		release_request();
		wait_response(data, resp_cycle);
		wait_idle();
		if (data !== memory_word(addr))
			flag_mismatch("resp_data", memory_word(addr), data);
		if (kind == KIND_HIT && resp_cycle - accept_cycle != 2)
			flag_problem($sformatf("Hit load at %h answered %0d cycles after acceptance, not 2",
				addr, resp_cycle - accept_cycle));
		check_beats(kind, addr, 32'h0);
		check_quiet();
	endtask

	// Memory always holds the newest value under write-through
	task automatic check_store(input logic [31:0] addr, input logic [31:0] value);
		int accept_cycle;
		int resp_cycle;
		logic [31:0] data;
		shadow_mem[addr] = value;
		drive_request(1'b1, addr, value, accept_cycle);
		release_request();
		wait_response(data, resp_cycle);
		wait_idle();
		check_beats(KIND_WRITE, addr, value);
		check_quiet();
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before)
		begin
			$display("%s: pass", name);
			tests_passed++;
		end
		else
		begin
			$display("%s: fail, %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	task automatic test_reset_state();
		int errors_before;
		errors_before = error_count;
		if (req_ready !== 1'b1)
			flag_mismatch("req_ready", 32'h1, 32'(req_ready));
		if (wb_cyc !== 1'b0)
			flag_mismatch("wb_cyc", 32'h0, 32'(wb_cyc));
		if (wb_stb !== 1'b0)
			flag_mismatch("wb_stb", 32'h0, 32'(wb_stb));
		if (wb_we !== 1'b0)
			flag_mismatch("wb_we", 32'h0, 32'(wb_we));
		if (resp_valid !== 1'b0)
			flag_mismatch("resp_valid", 32'h0, 32'(resp_valid));
		finish_test("reset state", errors_before);
	endtask

	task automatic test_miss_then_hits();
		int errors_before;
		int kind;
		int accepts[3];
		int resp_cycle;
		logic [31:0] addrs[3];
		logic [31:0] data;
		errors_before = error_count;
		check_load(32'h0000_1246);
		addrs[0] = 32'h0000_1244;
		addrs[1] = 32'h0000_1245;
		addrs[2] = 32'h0000_1247;
		// Rest of the line goes back to back
		for (int i = 0; i < 3; i++)
		begin
			predict_load(addrs[i], kind);
			drive_request(1'b0, addrs[i], 32'h0, accepts[i]);
		end
		release_request();
		for (int i = 0; i < 3; i++)
		begin
			wait_response(data, resp_cycle);
			if (data !== memory_word(addrs[i]))
				flag_mismatch("resp_data", memory_word(addrs[i]), data);
			if (resp_cycle - accepts[i] != 2)
				flag_problem($sformatf("Streamed load at %h answered %0d cycles after acceptance",
					addrs[i], resp_cycle - accepts[i]));
			if (i > 0 && accepts[i] != accepts[i - 1] + 1)
				flag_problem($sformatf("Streamed load at %h was not accepted back to back",
					addrs[i]));
		end
		wait_idle();
		check_beats(KIND_HIT, 32'h0, 32'h0);
		check_quiet();
		finish_test("load miss then hits", errors_before);
	endtask

	task automatic test_write_through();
		int errors_before;
		errors_before = error_count;
		// Store to a cached word whose reload must hit
		check_store(32'h0000_1245, 32'hcafe_0001);
		check_load(32'h0000_1245);
		// Store to an uncached line whose reload still fills
		check_store(32'h0000_2382, 32'h0bad_f00d);
		check_load(32'h0000_2382);
		finish_test("write-through stores", errors_before);
	endtask

	task automatic test_io_space();
		int errors_before;
		errors_before = error_count;
		check_load(32'hffff_0010);
		check_load(32'hffff_0010);
		check_load(32'hffff_0023);
		finish_test("I/O space", errors_before);
	endtask

	task automatic test_replacement();
		int errors_before;
		int pick;
		int word;
		logic [31:0] lines[5];
		errors_before = error_count;
		// Five tags in set 5 overflow the four ways
		for (int k = 0; k < 5; k++)
		begin
			lines[k] = (32'(256 + k) << 6) | 32'h14;
			check_load(lines[k] | 32'(k % 4));
		end
		repeat (12)
		begin
			draw_bits(3, pick);
			draw_bits(2, word);
			check_load(lines[pick % 5] | 32'(word));
		end
		finish_test("PLRU replacement", errors_before);
	endtask

	task automatic test_held_request();
		int errors_before;
		int kind;
		int accept_first;
		int accept_second;
		int resp_cycle;
		logic [31:0] data;
		errors_before = error_count;
		predict_load(32'h0000_3389, kind);
		predict_load(32'h0000_338b, kind);
		drive_request(1'b0, 32'h0000_3389, 32'h0, accept_first);
		drive_request(1'b0, 32'h0000_338b, 32'h0, accept_second);
		release_request();
		if (accept_second != accept_first + 1)
			flag_problem("Second load was not accepted in the cycle after the missing load");
		wait_response(data, resp_cycle);
		if (data !== memory_word(32'h0000_3389))
			flag_mismatch("resp_data", memory_word(32'h0000_3389), data);
		wait_response(data, resp_cycle);
		if (data !== memory_word(32'h0000_338b))
			flag_mismatch("resp_data", memory_word(32'h0000_338b), data);
		wait_idle();
		// One fill serves both loads
		check_beats(KIND_FILL, 32'h0000_3389, 32'h0);
		check_quiet();
		finish_test("held request after miss", errors_before);
	endtask

	initial
	begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_store = 1'b0;
		req_addr = '0;
		req_store_value = '0;
		for (int s = 0; s < L1D_SETS; s++)
		begin
			model_root[s] = 1'b0;
			model_pair[s][0] = 1'b0;
			model_pair[s][1] = 1'b0;
			for (int w = 0; w < L1D_WAYS; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_reset_state();
		test_miss_then_hits();
		test_write_through();
		test_io_space();
		test_replacement();
		test_held_request();
		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end
endmodule

`default_nettype wire

// File: test/wb_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_memory_model
	#(parameter logic [31:0] SEED = 32'hdefc)
	(input wire clk,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [31:0] wb_adr,
	input wire [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack);

	// Only words that were written are stored
	logic [31:0] written[logic [31:0]];
	logic [31:0] lfsr;
	logic [31:0] lfsr_one;
	logic [31:0] lfsr_two;
	logic started;
	logic [1:0] wait_left;
	logic respond;

	// Fibonacci LFSR, taps 32 22 2 1, new bit enters at the bottom
	function automatic logic [31:0] lfsr_advance(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Unwritten words hold a value built from the full address
	function automatic logic [31:0] initial_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
	endfunction

	assign lfsr_one = lfsr_advance(lfsr);
	assign lfsr_two = lfsr_advance(lfsr_one);

	// Ack once the drawn wait states have run out
	assign respond = wb_cyc && wb_stb && !wb_ack && started && wait_left == 2'd0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			wb_dat_r <= '0;
			started <= 1'b0;
			wait_left <= '0;
			lfsr <= SEED;
		end
		else
		begin
			// Ack lasts one cycle, master drops cyc after it
			wb_ack <= respond;
			if (respond)
			begin
				started <= 1'b0;
				wb_dat_r <= written.exists(wb_adr) ? written[wb_adr] : initial_word(wb_adr);
			end
			else if (wb_cyc && wb_stb && !wb_ack && !started)
			begin
				// Two LFSR bits give 0 to 3 wait states
				started <= 1'b1;
				wait_left <= {lfsr_one[0], lfsr_two[0]};
				lfsr <= lfsr_two;
			end
			else if (started && wait_left != 2'd0)
				wait_left <= wait_left - 2'd1;
		end
	end

	always @(posedge clk)
	begin
		if (!reset && respond && wb_we)
			written[wb_adr] = wb_dat_w;
	end
endmodule

`default_nettype wire

// File: vlog.f
source/l1d_pkg.sv
source/dcache_if.sv
source/sram_1r1w.sv
source/cache_lru.sv
source/dcache_tag_stage.sv
source/dcache_data_stage.sv
source/l1d_bus_fsm.sv
source/bus_beat_counter.sv
source/l1d_cache_top.sv
test/wb_memory_model.sv
test/dcache_tb.sv
